/* pfs_pkg.sv */
package pfs_pkg;

    // --------------------------------------------------
    // Sizes
    // --------------------------------------------------
    localparam int WORD_W     = 256;
    localparam int ADDR_W     = 22;
    localparam int FIFO_DEPTH = 8;
    localparam int CREDIT_W   = 4;
    localparam int PTR_W      = $clog2(FIFO_DEPTH);

    typedef logic [WORD_W-1:0] word_t;

    // Header word at address 0, most significant field first
    typedef struct packed {
        logic [31:0]        total_bits;
        logic [31:0]        pat_count;
        logic [7:0]         h_fill;
        logic [WORD_W-73:0] pad;
    } pat_header_t;

    // --------------------------------------------------
    // External memory and video
    // --------------------------------------------------
    typedef struct packed {
        logic              read;
        logic [ADDR_W-1:0] addr;
    } mem_req_t;

    typedef struct packed {
        logic  valid;
        word_t data;
    } mem_rsp_t;

    typedef struct packed {
        logic de;
        logic hs;
        logic vs;
    } video_sync_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    localparam rgb_t BLACK = '{r: 8'h00, g: 8'h00, b: 8'h00};
    localparam rgb_t WHITE = '{r: 8'hff, g: 8'hff, b: 8'hff};

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_HEAD,
        FETCH_HEAD_WAIT,
        FETCH_BODY
    } fetch_state_t;

    typedef enum logic [1:0] {
        SER_IDLE,
        SER_HEAD,
        SER_LOAD,
        SER_SHIFT
    } ser_state_t;

endpackage

/* pat_fetch.sv */
`timescale 1ns/100ps
module pat_fetch import pfs_pkg::*; (
    input  logic     pixel_clk,
    input  logic     pixel_rst_n,
    input  logic     start,
    input  logic     mem_ready,
    output mem_req_t mem_req,
    input  mem_rsp_t mem_rsp,
    input  logic     credit_return
);

    fetch_state_t      state;
    logic [ADDR_W-1:0] addr_q;
    logic [CREDIT_W-1:0] credits;
    logic [CREDIT_W-1:0] outstanding;
    logic [31:0]       body_left;
    logic [31:0]       words_per_pat;
    pat_header_t       hdr;
    logic              issue;
    logic              accept;

    assign hdr = pat_header_t'(mem_rsp.data);

    // ceil(total_bits / 256)
    assign words_per_pat = {8'd0, hdr.total_bits[31:8]} + 32'(|hdr.total_bits[7:0]);

    // Only request while a buffer slot is guaranteed
    assign issue = (state == FETCH_HEAD || (state == FETCH_BODY && body_left != 32'd0))
                   && credits != '0;
    assign accept = issue && mem_ready;

    assign mem_req = '{read: issue, addr: addr_q};

    always_ff @(posedge pixel_clk or negedge pixel_rst_n) begin
        if (!pixel_rst_n) begin
            state       <= FETCH_IDLE;
            addr_q      <= '0;
            credits     <= CREDIT_W'(FIFO_DEPTH);
            outstanding <= '0;
            body_left   <= '0;
        end else begin
            credits     <= credits - CREDIT_W'(accept) + CREDIT_W'(credit_return);
            outstanding <= outstanding + CREDIT_W'(accept) - CREDIT_W'(mem_rsp.valid);
            if (accept) begin
                addr_q <= addr_q + 1'b1;
            end

            case (state)
                FETCH_IDLE: begin
                    if (start) begin
                        addr_q <= '0;
                        state  <= FETCH_HEAD;
                    end
                end
                FETCH_HEAD: begin
                    if (accept) begin
                        state <= FETCH_HEAD_WAIT;
                    end
                end
                FETCH_HEAD_WAIT: begin
                    // Body length for the whole set, patterns are word aligned
                    if (mem_rsp.valid) begin
                        body_left <= words_per_pat * hdr.pat_count;
                        state     <= FETCH_BODY;
                    end
                end
                FETCH_BODY: begin
                    if (accept) begin
                        body_left <= body_left - 32'd1;
                    end
                    // Done once every response is back
                    if (body_left == 32'd0 && outstanding == '0) begin
                        state <= FETCH_IDLE;
                    end
                end
                default: begin
                    state <= FETCH_IDLE;
                end
            endcase
        end
    end

endmodule

/* word_fifo.sv */
`timescale 1ns/100ps
module word_fifo import pfs_pkg::*; (
    input  logic  pixel_clk,
    input  logic  pixel_rst_n,
    input  logic  wr_en,
    input  word_t wr_data,
    input  logic  pop,
    output logic  rd_ready,
    output word_t rd_data,
    output logic  credit_return
);

    word_t               mem [FIFO_DEPTH];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [CREDIT_W-1:0] count;
    logic                do_pop;

    assign rd_ready = count != '0;
    assign do_pop   = pop && rd_ready;

    // Storage and read register
    always_ff @(posedge pixel_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
        if (do_pop) begin
            rd_data <= mem[rd_ptr];
        end
    end

    // Pointers wrap on their own, depth is a power of two
    always_ff @(posedge pixel_clk or negedge pixel_rst_n) begin
        if (!pixel_rst_n) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count         <= count + CREDIT_W'(wr_en) - CREDIT_W'(do_pop);
            credit_return <= do_pop;
        end
    end

endmodule

/* pix_serializer.sv */
`timescale 1ns/100ps
module pix_serializer import pfs_pkg::*; (
    input  logic        pixel_clk,
    input  logic        pixel_rst_n,
    input  video_sync_t pixel_sync,
    input  logic        rd_ready,
    input  word_t       rd_data,
    output logic        pop,
    output video_sync_t gen_sync,
    output rgb_t        gen_rgb
);

    ser_state_t  state;
    pat_header_t hdr;
    logic [31:0] total_bits;
    logic [31:0] bits_left;
    logic [31:0] pats_left;
    logic [7:0]  h_fill;
    logic [7:0]  fill_cnt;
    logic [7:0]  bit_idx;
    logic        show_bit;
    logic        cur_bit;
    logic        bit_done;
    logic        pat_end;
    logic        set_end;
    logic        word_end;

    assign hdr = pat_header_t'(rd_data);

    // --------------------------------------------------
    // Bit selection and word boundaries
    // --------------------------------------------------
    assign show_bit = state == SER_SHIFT && pixel_sync.de;
    // MSB first
    assign cur_bit  = rd_data[~bit_idx];
    assign bit_done = show_bit && fill_cnt == h_fill;
    assign pat_end  = bits_left == 32'd1;
    assign set_end  = pat_end && pats_left == 32'd1;
    // Tail bits past total_bits are skipped by moving on early
    assign word_end = bit_done && (bit_idx == 8'hff || pat_end) && !set_end;

    assign pop = rd_ready && (state == SER_IDLE || state == SER_LOAD || word_end);

    always_ff @(posedge pixel_clk or negedge pixel_rst_n) begin
        if (!pixel_rst_n) begin
            state      <= SER_IDLE;
            total_bits <= '0;
            bits_left  <= '0;
            pats_left  <= '0;
            h_fill     <= '0;
            fill_cnt   <= '0;
            bit_idx    <= '0;
        end else begin
            case (state)
                SER_IDLE: begin
                    if (rd_ready) begin
                        state <= SER_HEAD;
                    end
                end
                SER_HEAD: begin
                    // Header word is on rd_data now
                    total_bits <= hdr.total_bits;
                    bits_left  <= hdr.total_bits;
                    pats_left  <= hdr.pat_count;
                    h_fill     <= hdr.h_fill;
                    fill_cnt   <= '0;
                    bit_idx    <= '0;
                    if (hdr.total_bits == 32'd0 || hdr.pat_count == 32'd0) begin
                        state <= SER_IDLE;
                    end else begin
                        state <= SER_LOAD;
                    end
                end
                SER_LOAD: begin
                    // Underflow waits here, pixels stay white
                    if (rd_ready) begin
                        state <= SER_SHIFT;
                    end
                end
                SER_SHIFT: begin
                    if (bit_done) begin
                        fill_cnt  <= '0;
                        bit_idx   <= bit_idx + 8'd1;
                        bits_left <= bits_left - 32'd1;
                        if (pat_end) begin
                            bit_idx   <= '0;
                            bits_left <= total_bits;
                            pats_left <= pats_left - 32'd1;
                        end
                        if (set_end) begin
                            state <= SER_IDLE;
                        end else if (word_end && !rd_ready) begin
                            state <= SER_LOAD;
                        end
                    end else if (show_bit) begin
                        fill_cnt <= fill_cnt + 8'd1;
                    end
                end
                default: begin
                    state <= SER_IDLE;
                end
            endcase
        end
    end

    // --------------------------------------------------
    // Output register, one cycle behind pixel_sync
    // --------------------------------------------------
    always_ff @(posedge pixel_clk or negedge pixel_rst_n) begin
        if (!pixel_rst_n) begin
            gen_sync <= '{de: 1'b0, hs: 1'b1, vs: 1'b1};
            gen_rgb  <= WHITE;
        end else begin
            gen_sync <= pixel_sync;
            if (show_bit && cur_bit) begin
                gen_rgb <= BLACK;
            end else begin
                gen_rgb <= WHITE;
            end
        end
    end

endmodule

/* pattern_fetch_send.sv */
`timescale 1ns/100ps
module pattern_fetch_send import pfs_pkg::*; (
    input  logic        pixel_clk,
    input  logic        pixel_rst_n,
    input  logic        start,
    input  video_sync_t pixel_sync,
    input  logic        mem_ready,
    output mem_req_t    mem_req,
    input  mem_rsp_t    mem_rsp,
    output video_sync_t gen_sync,
    output rgb_t        gen_rgb
);

    logic  credit_return;
    logic  fifo_pop;
    logic  fifo_rd_ready;
    word_t fifo_rd_data;

    // Memory read side
    pat_fetch u_pat_fetch (
        .pixel_clk     (pixel_clk),
        .pixel_rst_n   (pixel_rst_n),
        .start         (start),
        .mem_ready     (mem_ready),
        .mem_req       (mem_req),
        .mem_rsp       (mem_rsp),
        .credit_return (credit_return)
    );

    // Every response goes straight into the buffer
    word_fifo u_word_fifo (
        .pixel_clk     (pixel_clk),
        .pixel_rst_n   (pixel_rst_n),
        .wr_en         (mem_rsp.valid),
        .wr_data       (mem_rsp.data),
        .pop           (fifo_pop),
        .rd_ready      (fifo_rd_ready),
        .rd_data       (fifo_rd_data),
        .credit_return (credit_return)
    );

    pix_serializer u_pix_serializer (
        .pixel_clk   (pixel_clk),
        .pixel_rst_n (pixel_rst_n),
        .pixel_sync  (pixel_sync),
        .rd_ready    (fifo_rd_ready),
        .rd_data     (fifo_rd_data),
        .pop         (fifo_pop),
        .gen_sync    (gen_sync),
        .gen_rgb     (gen_rgb)
    );

endmodule

/* pfs_chk.sv */
`timescale 1ns/100ps
module pfs_chk import pfs_pkg::*; (
    input logic                pixel_clk,
    input logic                pixel_rst_n,
    input mem_req_t            mem_req,
    input logic                mem_ready,
    input logic                credit_return,
    input logic [CREDIT_W-1:0] credits
);

    int spent;

    // Words in flight or held in the buffer, seen from the ports
    always_ff @(posedge pixel_clk or negedge pixel_rst_n) begin
        if (!pixel_rst_n) begin
            spent <= 0;
        end else begin
            spent <= spent + int'(mem_req.read && mem_ready) - int'(credit_return);
        end
    end

    // A request needs a free buffer slot
    a_read_credit: assert property (@(posedge pixel_clk) disable iff (!pixel_rst_n)
        mem_req.read |-> spent < FIFO_DEPTH)
        else $error("read issued with no credits left");

    a_credit_max: assert property (@(posedge pixel_clk) disable iff (!pixel_rst_n)
        credits <= CREDIT_W'(FIFO_DEPTH))
        else $error("credit count above buffer depth");

    // Stalled request keeps its address
    a_addr_hold: assert property (@(posedge pixel_clk) disable iff (!pixel_rst_n)
        mem_req.read && !mem_ready |=> $stable(mem_req.addr))
        else $error("read address changed while stalled");

endmodule

/* pfs_checker.sv */
`timescale 1ns/100ps
module pfs_checker import pfs_pkg::*; (
    input  logic        pixel_clk,
    input  logic        pixel_rst_n,
    input  logic        start,
    input  logic        row_done,
    input  int          total_bits,
    input  int          pat_count,
    input  int          h_fill,
    input  logic [7:0]  fill,
    input  video_sync_t pixel_sync,
    input  logic        mem_ready,
    input  mem_req_t    mem_req,
    input  video_sync_t gen_sync,
    input  rgb_t        gen_rgb,
    output int          error_count
);

    video_sync_t prev_sync;
    logic        started;
    logic        seen_de;
    int          pix_idx;
    int          reads;
    int          exp_addr;
    int          exp_reads;
    int          total_px;
    rgb_t        exp_rgb;

    // Body word content, depends on the whole address
    function automatic word_t body_word(input int addr, input logic [7:0] fill_byte);
        word_t w;
        for (int i = 0; i < WORD_W / 32; i++) begin
            w[i*32 +: 32] = {4{fill_byte}} ^ (32'(addr) * 32'h9e3779b1) ^ 32'(i);
        end
        return w;
    endfunction

    // Pattern bit behind expanded pixel idx, patterns start on a new word
    function automatic logic pattern_bit(input int idx);
        int    b;
        int    p;
        int    k;
        int    wpp;
        word_t w;
        b   = idx / (h_fill + 1);
        p   = b / total_bits;
        k   = b % total_bits;
        wpp = (total_bits + WORD_W - 1) / WORD_W;
        w   = body_word(1 + p * wpp + k / WORD_W, fill);
        return w[WORD_W - 1 - k % WORD_W];
    endfunction

    assign total_px  = total_bits * pat_count * (h_fill + 1);
    // Header plus whole words for every pattern
    assign exp_reads = 1 + (total_bits + WORD_W - 1) / WORD_W * pat_count;

    initial begin
        error_count = 0;
    end

    always @(posedge pixel_clk) begin
        if (!pixel_rst_n) begin
            prev_sync = '{de: 1'b0, hs: 1'b1, vs: 1'b1};
            started   = 1'b0;
            seen_de   = 1'b0;
            pix_idx   = 0;
            reads     = 0;
            exp_addr  = 0;
        end else begin
            if (gen_sync != prev_sync) begin
                $display("FAIL %0t gen_sync: got %b expected %b", $time, gen_sync, prev_sync);
                error_count++;
            end
            if (!started && mem_req.read) begin
                $display("ERROR %0t: memory read requested before any start", $time);
                error_count++;
            end
            if (!gen_sync.de && gen_rgb != WHITE) begin
                $display("FAIL %0t gen_rgb: got %h expected %h", $time, gen_rgb, WHITE);
                error_count++;
            end
            if (gen_sync.de) begin
                exp_rgb = (pix_idx < total_px && pattern_bit(pix_idx)) ? BLACK : WHITE;
                if (gen_rgb != exp_rgb) begin
                    $display("FAIL %0t gen_rgb: got %h expected %h", $time, gen_rgb, exp_rgb);
                    error_count++;
                end
                pix_idx++;
            end
            // Header first, then the body in address order
            if (mem_req.read && mem_ready) begin
                if (mem_req.addr != ADDR_W'(exp_addr)) begin
                    $display("FAIL %0t mem_req.addr: got %0d expected %0d", $time,
                             mem_req.addr, exp_addr);
                    error_count++;
                end
                exp_addr++;
            end
            // Header, a full buffer and the word on the read register
            if (!seen_de && mem_req.read && mem_ready) begin
                reads++;
                if (reads > FIFO_DEPTH + 2) begin
                    $display("ERROR %0t: more reads accepted than the buffer can hold", $time);
                    error_count++;
                end
            end
            if (pixel_sync.de) begin
                seen_de = 1'b1;
            end
            if (row_done && pix_idx != total_px) begin
                $display("ERROR %0t: row ended after %0d of %0d pixels", $time, pix_idx, total_px);
                error_count++;
            end
            if (row_done && exp_addr != exp_reads) begin
                $display("ERROR %0t: %0d reads accepted where %0d were due", $time,
                         exp_addr, exp_reads);
                error_count++;
            end
            if (start) begin
                started  = 1'b1;
                seen_de  = 1'b0;
                pix_idx  = 0;
                reads    = 0;
                exp_addr = 0;
            end
            prev_sync = pixel_sync;
        end
    end

endmodule

/* tb_pattern_fetch_send.sv */
`timescale 1ns/100ps
module tb_pattern_fetch_send
    import pfs_pkg::*;
();

    typedef struct packed {
        logic [31:0] total_bits;
        logic [31:0] pat_count;
        logic [7:0]  h_fill;
        logic [7:0]  fill;
        logic [7:0]  hold;
    } row_t;

    logic              pixel_clk;
    logic              pixel_rst_n;
    logic              start;
    logic              row_done;
    logic              mem_ready;
    video_sync_t       pixel_sync;
    video_sync_t       gen_sync;
    mem_req_t          mem_req;
    mem_rsp_t          mem_rsp;
    rgb_t              gen_rgb;
    row_t              row;
    row_t              rows [$];
    word_t             mem_img [64];
    logic [ADDR_W-1:0] rsp_addr_q [$];
    int                rsp_due_q [$];
    int                seed;
    int                cyc;
    int                last_due;
    int                ready_hold;
    int                limit;
    int                error_count;

    pattern_fetch_send u_dut (.*);

    pfs_checker u_checker (
        .pixel_clk   (pixel_clk),
        .pixel_rst_n (pixel_rst_n),
        .start       (start),
        .row_done    (row_done),
        .total_bits  (int'(row.total_bits)),
        .pat_count   (int'(row.pat_count)),
        .h_fill      (int'(row.h_fill)),
        .fill        (row.fill),
        .pixel_sync  (pixel_sync),
        .mem_ready   (mem_ready),
        .mem_req     (mem_req),
        .gen_sync    (gen_sync),
        .gen_rgb     (gen_rgb),
        .error_count (error_count)
    );

    bind pat_fetch pfs_chk u_pfs_chk (
        .pixel_clk     (pixel_clk),
        .pixel_rst_n   (pixel_rst_n),
        .mem_req       (mem_req),
        .mem_ready     (mem_ready),
        .credit_return (credit_return),
        .credits       (credits)
    );

    always #2 pixel_clk = ~pixel_clk;

    function automatic word_t body_word(input int addr, input logic [7:0] fill_byte);
        word_t w;
        for (int i = 0; i < WORD_W / 32; i++) begin
            w[i*32 +: 32] = {4{fill_byte}} ^ (32'(addr) * 32'h9e3779b1) ^ 32'(i);
        end
        return w;
    endfunction

    function automatic int pixel_count(input row_t r);
        return int'(r.total_bits) * int'(r.pat_count) * (int'(r.h_fill) + 1);
    endfunction

    task automatic next_cycle();
        @(posedge pixel_clk);
        #1;
    endtask

    // --------------------------------------------------
    // Memory model, in order, 1 to 4 cycles latency
    // --------------------------------------------------
    always @(posedge pixel_clk) begin
        int lat;
        int due;
        if (start) begin
            ready_hold = int'(row.hold);
        end
        if (pixel_rst_n && mem_req.read && mem_ready) begin
            lat = 1 + ($random(seed) & 3);
            due = cyc + lat;
            if (due <= last_due) begin
                due = last_due + 1;
            end
            last_due = due;
            rsp_addr_q.push_back(mem_req.addr);
            rsp_due_q.push_back(due);
        end
        cyc = cyc + 1;
        #1;
        if (rsp_due_q.size() != 0 && rsp_due_q[0] <= cyc) begin
            mem_rsp = '{valid: 1'b1, data: mem_img[rsp_addr_q[0][5:0]]};
            void'(rsp_addr_q.pop_front());
            void'(rsp_due_q.pop_front());
        end else begin
            mem_rsp = '0;
        end
        if (ready_hold > 0) begin
            mem_ready  = 1'b0;
            ready_hold = ready_hold - 1;
        end else begin
            mem_ready = ($random(seed) & 3) != 0;
        end
        if (cyc > limit) begin
            $display("ERROR: run did not finish within %0d cycles", limit);
            $display("Errors: %0d", error_count + 1);
            $display("Verification failed");
            $finish;
        end
    end

    // Lines of 64 pixels with a blank gap and an hs pulse
    task automatic show_lines(input int total);
        int rem;
        int n;
        rem = total;
        while (rem > 0) begin
            n = (rem < 64) ? rem : 64;
            pixel_sync.de = 1'b1;
            repeat (n) next_cycle();
            rem = rem - n;
            pixel_sync.de = 1'b0;
            pixel_sync.hs = 1'b0;
            repeat (4) next_cycle();
            pixel_sync.hs = 1'b1;
            repeat (12) next_cycle();
        end
    endtask

    task automatic run_row(input row_t r);
        pat_header_t hdr;
        hdr            = '0;
        hdr.total_bits = r.total_bits;
        hdr.pat_count  = r.pat_count;
        hdr.h_fill     = r.h_fill;
        row = r;
        for (int a = 0; a < 64; a++) begin
            mem_img[a] = body_word(a, r.fill);
        end
        mem_img[0] = word_t'(hdr);
        start = 1'b1;
        next_cycle();
        start = 1'b0;
        repeat (100) next_cycle();
        show_lines(pixel_count(r));
        row_done = 1'b1;
        next_cycle();
        row_done = 1'b0;
    endtask

    initial begin
        pixel_clk   = 1'b0;
        pixel_rst_n = 1'b0;
        start       = 1'b0;
        row_done    = 1'b0;
        mem_ready   = 1'b0;
        mem_rsp     = '0;
        pixel_sync  = '{de: 1'b0, hs: 1'b1, vs: 1'b1};
        row         = '0;
        seed        = 32'hefd8;
        cyc         = 0;
        last_due    = 0;
        ready_hold  = 0;
        // total_bits, pat_count, h_fill, fill byte, mem_ready low cycles after start
        rows.push_back(row_t'{32'd40,  32'd1, 8'd0, 8'ha5, 8'd0});
        rows.push_back(row_t'{32'd100, 32'd1, 8'd2, 8'h3c, 8'd0});
        rows.push_back(row_t'{32'd300, 32'd3, 8'd0, 8'h5a, 8'd0});
        rows.push_back(row_t'{32'd520, 32'd4, 8'd1, 8'hc3, 8'd20});
        limit = 1000;
        foreach (rows[i]) begin
            limit += 2 * pixel_count(rows[i]);
        end
        repeat (5) @(posedge pixel_clk);
        #1;
        pixel_rst_n = 1'b1;
        repeat (10) next_cycle();
        foreach (rows[i]) begin
            run_row(rows[i]);
        end
        repeat (10) next_cycle();
        $display("Errors: %0d", error_count);
        if (error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* src.f */
pfs_pkg.sv
pat_fetch.sv
word_fifo.sv
pix_serializer.sv
pattern_fetch_send.sv
pfs_chk.sv
pfs_checker.sv
tb_pattern_fetch_send.sv

/* Makefile */
TOOL  = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP   = tb_pattern_fetch_send
FLIST = src.f
OBJ   = obj_dir
LOG   = sim.log

.PHONY: help test clean

help:
	@echo "test  - build and run the simulation, fail on a failed run"
	@echo "clean - remove build output and log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ)
	./$(OBJ)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@! grep -q "Verification failed" $(LOG)
	@grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)
